//--- common/bch_pkg.sv
// BCH(15,11) over GF(16) with x^4+x+1, single error correction only, bit 14 is the first bit sent
`default_nettype none

package bch_pkg;

	localparam int bch_n = 15;
	localparam int bch_k = 11;
	localparam int bch_m = 4;

	typedef logic [bch_k-1:0] bch_data_t;

	// Bits 14 to 4 carry the data word, bits 3 to 0 the parity
	typedef logic [bch_n-1:0] codeword_t;

	typedef logic [bch_m-1:0] gf_elem_t;
	typedef logic [3:0] slot_t;

	// Generator x^4+x+1 without its leading term
	localparam gf_elem_t bch_generator = 4'b0011;

	// Multiply by alpha and reduce by x^4+x+1
	function automatic gf_elem_t gf_mul_alpha(input gf_elem_t a);
		gf_elem_t shifted;
		shifted = {a[bch_m-2:0], 1'b0};
		if (a[bch_m-1]) begin
			shifted = shifted ^ bch_generator;
		end
		return shifted;
	endfunction

endpackage

`default_nettype wire

//--- common/codec_regs_pkg.sv
// Register map and store bus types, 8-bit byte offsets and 32-bit APB data
`default_nettype none

package codec_regs_pkg;

	import bch_pkg::*;

	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	localparam apb_addr_t reg_enc_cmd = 8'h00;
	localparam apb_addr_t reg_err_inject = 8'h04;
	localparam apb_addr_t reg_dec_cmd = 8'h08;
	localparam apb_addr_t reg_status = 8'h0C;
	localparam apb_addr_t reg_result = 8'h10;
	localparam apb_addr_t reg_raw = 8'h14;

	typedef enum logic [1:0] {
		store_read,
		store_write,
		store_xor
	} store_op_e;

	typedef struct packed {
		logic valid;
		store_op_e op;
		slot_t slot;
		codeword_t word;
	} store_req_t;

	typedef struct packed {
		logic grant;
		logic rvalid;
		codeword_t rdata;
	} store_rsp_t;

	// Readback layout is data in bits 15:5, err_found in bit 4 and err_pos in bits 3:0
	typedef struct packed {
		bch_data_t data;
		logic err_found;
		logic [3:0] err_pos;
	} codec_result_t;

endpackage

`default_nettype wire

//--- logic/apb_regs.sv
// APB slave with no wait states, one injection may be pending at a time, slots at or above num_slots fail
`timescale 1ns/1ps
`default_nettype none

module apb_regs
	import bch_pkg::*;
	import codec_regs_pkg::*;
#(
	parameter int num_slots = 16
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire apb_addr_t paddr,
	input wire apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic enc_start,
	output slot_t enc_slot,
	output bch_data_t enc_data,
	output logic dec_start,
	output slot_t dec_slot,
	input wire logic enc_busy,
	input wire logic dec_busy,
	input wire logic dec_done,
	input wire codec_result_t dec_result,
	input wire codeword_t dec_raw,
	output store_req_t inj_req,
	input wire store_rsp_t inj_rsp
);

	logic access;
	logic wr;
	logic slot_bad;
	logic bad;
	logic enc_ok;
	logic dec_ok;
	logic inj_ok;
	codec_result_t result_q;
	codeword_t raw_q;

	assign access = psel && penable;
	assign wr = access && pwrite;
	assign slot_bad = int'(pwdata[3:0]) >= num_slots;

	// ##################################################
	// Transfer decode and error response

	always_comb begin
		bad = 1'b0;
		case (paddr)
			reg_enc_cmd: bad = pwrite && (enc_busy || enc_start || slot_bad);
			reg_dec_cmd: bad = pwrite && (dec_busy || dec_start || slot_bad);
			reg_err_inject: bad = pwrite && (inj_req.valid || slot_bad);
			reg_status, reg_result, reg_raw: bad = 1'b0;
			default: bad = 1'b1;
		endcase
	end

	assign pready = 1'b1;
	assign pslverr = access && bad;

	assign enc_ok = wr && !bad && paddr == reg_enc_cmd;
	assign dec_ok = wr && !bad && paddr == reg_dec_cmd;
	assign inj_ok = wr && !bad && paddr == reg_err_inject;

	always_ff @(posedge clk) begin
		if (reset) begin
			enc_start <= 1'b0;
			dec_start <= 1'b0;
			inj_req <= '0;
		end else begin
			enc_start <= enc_ok;
			dec_start <= dec_ok;
			if (inj_ok) begin
				inj_req <= '{valid: 1'b1, op: store_xor, slot: pwdata[3:0],
					word: pwdata[30:16]};
			end else if (inj_rsp.grant) begin
				inj_req.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (enc_ok) begin
			enc_slot <= pwdata[3:0];
			enc_data <= pwdata[26:16];
		end
		if (dec_ok) begin
			dec_slot <= pwdata[3:0];
		end
		if (dec_done) begin
			result_q <= dec_result;
			raw_q <= dec_raw;
		end
	end

	// ##################################################
	// Readback

	always_comb begin
		case (paddr)
			reg_status: prdata = {29'b0, inj_req.valid, dec_busy, enc_busy};
			reg_result: prdata = {16'b0, result_q};
			reg_raw: prdata = {17'b0, raw_q};
			default: prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- encoder/bch_encoder.sv
// Serial systematic encoder, one data bit per cycle MSB first, start is ignored while busy
`timescale 1ns/1ps
`default_nettype none

module bch_encoder
	import bch_pkg::*;
	import codec_regs_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire slot_t slot,
	input wire bch_data_t data,
	output logic busy,
	output store_req_t req,
	input wire store_rsp_t rsp
);

	typedef enum logic [1:0] {
		idle,
		shift,
		store
	} enc_state_e;

	localparam logic [3:0] last_bit = 4'(bch_k - 1);

	enc_state_e state;
	logic [3:0] cnt;
	gf_elem_t lfsr;
	slot_t slot_q;
	bch_data_t data_q;
	logic in_bit;
	logic feedback;

	assign in_bit = data_q[last_bit - cnt];
	assign feedback = in_bit ^ lfsr[bch_m-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			cnt <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= shift;
						cnt <= '0;
					end
				end
				shift: begin
					cnt <= cnt + 4'd1;
					if (cnt == last_bit) begin
						state <= store;
					end
				end
				default: begin
					// Hold the write until the store takes it
					if (rsp.grant) begin
						state <= idle;
					end
				end
			endcase
		end
	end

	// The remainder of data times x^4 divided by the generator
	always_ff @(posedge clk) begin
		if (state == idle && start) begin
			lfsr <= '0;
			slot_q <= slot;
			data_q <= data;
		end else if (state == shift) begin
			lfsr <= {lfsr[bch_m-2:0], 1'b0} ^ (feedback ? bch_generator : gf_elem_t'(0));
		end
	end

	assign busy = state != idle;

	assign req.valid = state == store;
	assign req.op = store_write;
	assign req.slot = slot_q;
	assign req.word = {data_q, lfsr};

endmodule

`default_nettype wire

//--- decoder/bch_decoder.sv
// Single error decoder, fixed 31 cycles from read data to result, raw is the codeword as stored
`timescale 1ns/1ps
`default_nettype none

module bch_decoder
	import bch_pkg::*;
	import codec_regs_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire slot_t slot,
	output logic busy,
	output logic done,
	output codec_result_t result,
	output codeword_t raw,
	output store_req_t req,
	input wire store_rsp_t rsp
);

	typedef enum logic [2:0] {
		idle,
		fetch,
		syndrome,
		search,
		report
	} dec_state_e;

	localparam logic [3:0] last_pos = 4'(bch_n - 1);

	dec_state_e state;
	logic [3:0] cnt;
	logic req_sent;
	slot_t slot_q;
	gf_elem_t syn;
	gf_elem_t power;
	logic err_found;
	logic [3:0] err_pos;
	codeword_t flip;
	codeword_t corrected;

	// ##################################################
	// Control

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			cnt <= '0;
			req_sent <= 1'b0;
		end else begin
			case (state)
				idle: begin
					req_sent <= 1'b0;
					if (start) begin
						state <= fetch;
					end
				end
				fetch: begin
					if (rsp.grant) begin
						req_sent <= 1'b1;
					end
					if (rsp.rvalid) begin
						state <= syndrome;
						cnt <= '0;
					end
				end
				syndrome, search: begin
					cnt <= cnt + 4'd1;
					if (cnt == last_pos) begin
						cnt <= '0;
						state <= state == syndrome ? search : report;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// ##################################################
	// Datapath

	always_ff @(posedge clk) begin
		if (state == idle && start) begin
			slot_q <= slot;
		end
		if (state == fetch && rsp.rvalid) begin
			raw <= rsp.rdata;
			syn <= '0;
		end
		// Horner step, S1 = c(alpha) with the highest position first
		if (state == syndrome) begin
			syn <= gf_mul_alpha(syn) ^ gf_elem_t'(raw[last_pos - cnt]);
			power <= gf_elem_t'(1);
			err_found <= 1'b0;
			err_pos <= '0;
		end
		// Position cnt holds the error when alpha^cnt equals S1, a zero syndrome never matches
		if (state == search) begin
			power <= gf_mul_alpha(power);
			if (power == syn) begin
				err_found <= 1'b1;
				err_pos <= cnt;
			end
		end
	end

	assign flip = codeword_t'(err_found) << err_pos;
	assign corrected = raw ^ flip;

	assign result.data = corrected[bch_n-1:bch_m];
	assign result.err_found = err_found;
	assign result.err_pos = err_pos;

	assign done = state == report;
	assign busy = state == fetch || state == syndrome || state == search;

	assign req.valid = state == fetch && !req_sent;
	assign req.op = store_read;
	assign req.slot = slot_q;
	assign req.word = '0;

endmodule

`default_nettype wire

//--- logic/codeword_store.sv
// Codeword array, num_slots a power of two from 2 to 16, upper slot bits are ignored
`timescale 1ns/1ps
`default_nettype none

module codeword_store
	import bch_pkg::*;
	import codec_regs_pkg::*;
#(
	parameter int num_slots = 16
) (
	input wire logic clk,
	input wire logic reset,
	input wire store_req_t enc_req,
	input wire store_req_t dec_req,
	input wire store_req_t inj_req,
	output store_rsp_t enc_rsp,
	output store_rsp_t dec_rsp,
	output store_rsp_t inj_rsp
);

	localparam int aw = $clog2(num_slots);

	codeword_t mem [num_slots];
	store_req_t req [3];
	logic [1:0] rr;
	logic [1:0] win;
	logic win_valid;
	logic [2:0] grant;
	logic [2:0] rvalid;
	codeword_t rdata;
	logic [aw-1:0] addr;

	assign req[0] = enc_req;
	assign req[1] = dec_req;
	assign req[2] = inj_req;

	// ##################################################
	// Round-robin pick starting at rr

	always_comb begin
		logic [2:0] sum;
		logic [1:0] cand;
		win = rr;
		win_valid = 1'b0;
		for (int i = 2; i >= 0; i--) begin
			sum = {1'b0, rr} + 3'(i);
			cand = sum >= 3'd3 ? 2'(sum - 3'd3) : sum[1:0];
			if (req[cand].valid) begin
				win = cand;
				win_valid = 1'b1;
			end
		end
	end

	assign grant[0] = win_valid && win == 2'd0;
	assign grant[1] = win_valid && win == 2'd1;
	assign grant[2] = win_valid && win == 2'd2;

	assign addr = req[win].slot[aw-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			rr <= '0;
			rvalid <= '0;
			for (int s = 0; s < num_slots; s++) begin
				mem[s] <= '0;
			end
		end else begin
			rvalid <= '0;
			if (win_valid) begin
				rr <= win == 2'd2 ? 2'd0 : win + 2'd1;
				case (req[win].op)
					store_write: mem[addr] <= req[win].word;
					store_xor: mem[addr] <= mem[addr] ^ req[win].word;
					default: rvalid[win] <= 1'b1;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid && req[win].op == store_read) begin
			rdata <= mem[addr];
		end
	end

	assign enc_rsp = '{grant: grant[0], rvalid: rvalid[0], rdata: rdata};
	assign dec_rsp = '{grant: grant[1], rvalid: rvalid[1], rdata: rdata};
	assign inj_rsp = '{grant: grant[2], rvalid: rvalid[2], rdata: rdata};

endmodule

`default_nettype wire

//--- logic/bch_codec_top.sv
// BCH(15,11) codec behind APB, PREADY is tied high and software polls status for completion
`timescale 1ns/1ps
`default_nettype none

module bch_codec_top
	import bch_pkg::*;
	import codec_regs_pkg::*;
#(
	parameter int num_slots = 16
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire apb_addr_t paddr,
	input wire apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

	logic enc_start;
	slot_t enc_slot;
	bch_data_t enc_data;
	logic enc_busy;
	logic dec_start;
	slot_t dec_slot;
	logic dec_busy;
	logic dec_done;
	codec_result_t dec_result;
	codeword_t dec_raw;
	store_req_t enc_req;
	store_req_t dec_req;
	store_req_t inj_req;
	store_rsp_t enc_rsp;
	store_rsp_t dec_rsp;
	store_rsp_t inj_rsp;

	apb_regs #(.num_slots(num_slots)) u_apb_regs (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.enc_start(enc_start), .enc_slot(enc_slot), .enc_data(enc_data),
		.dec_start(dec_start), .dec_slot(dec_slot),
		.enc_busy(enc_busy), .dec_busy(dec_busy), .dec_done(dec_done),
		.dec_result(dec_result), .dec_raw(dec_raw),
		.inj_req(inj_req), .inj_rsp(inj_rsp)
	);

	bch_encoder u_bch_encoder (
		.clk(clk), .reset(reset), .start(enc_start), .slot(enc_slot), .data(enc_data),
		.busy(enc_busy), .req(enc_req), .rsp(enc_rsp)
	);

	bch_decoder u_bch_decoder (
		.clk(clk), .reset(reset), .start(dec_start), .slot(dec_slot),
		.busy(dec_busy), .done(dec_done), .result(dec_result), .raw(dec_raw),
		.req(dec_req), .rsp(dec_rsp)
	);

	codeword_store #(.num_slots(num_slots)) u_codeword_store (
		.clk(clk), .reset(reset),
		.enc_req(enc_req), .dec_req(dec_req), .inj_req(inj_req),
		.enc_rsp(enc_rsp), .dec_rsp(dec_rsp), .inj_rsp(inj_rsp)
	);

endmodule

`default_nettype wire

//--- dv/bch_codec_asserts.sv
// Watches the store bus and APB wires of bch_codec_top, silent while reset is high
`timescale 1ns/1ps
`default_nettype none

module bch_codec_asserts
	import bch_pkg::*;
	import codec_regs_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire store_req_t enc_req,
	input wire store_req_t dec_req,
	input wire store_req_t inj_req,
	input wire store_rsp_t enc_rsp,
	input wire store_rsp_t dec_rsp,
	input wire store_rsp_t inj_rsp,
	input wire logic psel,
	input wire logic penable,
	input wire logic pslverr
);

	logic [2:0] grants;
	logic [2:0] valids;
	logic [2:0] read_grants;
	logic [2:0] rvalids;

	assign grants = {inj_rsp.grant, dec_rsp.grant, enc_rsp.grant};
	assign valids = {inj_req.valid, dec_req.valid, enc_req.valid};
	assign rvalids = {inj_rsp.rvalid, dec_rsp.rvalid, enc_rsp.rvalid};
	assign read_grants[0] = enc_rsp.grant && enc_req.op == store_read;
	assign read_grants[1] = dec_rsp.grant && dec_req.op == store_read;
	assign read_grants[2] = inj_rsp.grant && inj_req.op == store_read;

	// ##################################################
	// Arbiter

	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grants))
		else $error("More than one store grant in a cycle");

	grant_needs_valid: assert property (@(posedge clk) disable iff (reset)
		(grants & ~valids) == 3'b000)
		else $error("Store grant given to an idle requester");

	rvalid_after_read: assert property (@(posedge clk) disable iff (reset)
		rvalids == $past(read_grants))
		else $error("Read data valid does not follow its grant by one cycle");

	// ##################################################
	// APB

	slverr_in_access: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> psel && penable)
		else $error("PSLVERR raised outside an access cycle");

endmodule

bind bch_codec_top bch_codec_asserts u_bch_codec_asserts (
	.clk(clk), .reset(reset),
	.enc_req(enc_req), .dec_req(dec_req), .inj_req(inj_req),
	.enc_rsp(enc_rsp), .dec_rsp(dec_rsp), .inj_rsp(inj_rsp),
	.psel(psel), .penable(penable), .pslverr(pslverr)
);

`default_nettype wire

//--- dv/bch_codec_tb.sv
// Expects num_slots of 16 and gives up on any status poll after 200 cycles
`timescale 1ns/1ps
`default_nettype none

module bch_codec_tb
	import bch_pkg::*;
	import codec_regs_pkg::*;
();

	localparam time clk_period = 8ns;
	localparam time sample_delay = 3ns;
	localparam int poll_limit = 200;
	localparam int num_entries = 22;

	typedef struct {
		string name;
		slot_t slot;
		bch_data_t data;
		codeword_t mask;
		codec_result_t exp;
	} test_entry_t;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	test_entry_t entries [num_entries];

	bch_codec_top #(.num_slots(16)) u_bch_codec_top (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ##################################################
	// Reference model and compare tasks

	// Long division of data * x^4 by x^4+x+1
	function automatic codeword_t reference_codeword(input bch_data_t data);
		logic [bch_n-1:0] rem;
		rem = {data, 4'b0000};
		for (int i = bch_n - 1; i >= bch_m; i--) begin
			if (rem[i]) begin
				rem = rem ^ (15'b000_0000_0001_0011 << (i - bch_m));
			end
		end
		return {data, rem[bch_m-1:0]};
	endfunction

	task automatic stop_with_failure();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	task automatic check_result(input string name, input codec_result_t exp,
			input codec_result_t act);
		if (exp !== act) begin
			$display("error: %s result expected %h actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_codeword(input string name, input codeword_t exp, input codeword_t act);
		if (exp !== act) begin
			$display("error: %s codeword expected %h actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_slverr(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("error: %s pslverr expected %b actual %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("error: %s pready expected %b actual %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	// ##################################################
	// APB driver

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#(sample_delay);
		err = pslverr;
		check_ready($sformatf("write_%02h", addr), 1'b1, pready);
		@(posedge clk);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#(sample_delay);
		data = prdata;
		err = pslverr;
		check_ready($sformatf("read_%02h", addr), 1'b1, pready);
		@(posedge clk);
	endtask

	task automatic wait_status_clear(input int bit_idx, input string what);
		apb_data_t status;
		logic err;
		int cycles;
		cycles = 0;
		apb_read(reg_status, status, err);
		while (status[bit_idx]) begin
			cycles += 2;
			if (cycles > poll_limit) begin
				$display("Timed out waiting for the %s to finish", what);
				stop_with_failure();
			end else begin
				apb_read(reg_status, status, err);
			end
		end
	endtask

	// ##################################################
	// Table steps

	task automatic encode_entry(input int i);
		logic err;
		apb_write(reg_enc_cmd, {5'b0, entries[i].data, 12'b0, entries[i].slot}, err);
		check_slverr(entries[i].name, 1'b0, err);
	endtask

	task automatic inject_entry(input int i);
		logic err;
		if (entries[i].mask != '0) begin
			apb_write(reg_err_inject, {1'b0, entries[i].mask, 12'b0, entries[i].slot}, err);
			check_slverr(entries[i].name, 1'b0, err);
		end
	endtask

	task automatic decode_entry(input int i);
		logic err;
		apb_write(reg_dec_cmd, {28'b0, entries[i].slot}, err);
		check_slverr(entries[i].name, 1'b0, err);
	endtask

	task automatic verify_entry(input int i);
		apb_data_t rdata;
		logic err;
		apb_read(reg_result, rdata, err);
		check_slverr(entries[i].name, 1'b0, err);
		check_result(entries[i].name, entries[i].exp, codec_result_t'(rdata[15:0]));
		apb_read(reg_raw, rdata, err);
		check_slverr(entries[i].name, 1'b0, err);
		check_codeword(entries[i].name, reference_codeword(entries[i].data) ^ entries[i].mask,
			rdata[14:0]);
	endtask

	task automatic run_entry(input int i);
		encode_entry(i);
		wait_status_clear(0, "encoder");
		inject_entry(i);
		wait_status_clear(2, "error injection");
		decode_entry(i);
		wait_status_clear(1, "decoder");
		verify_entry(i);
	endtask

	task automatic add_entry(input int i, input string name, input bch_data_t data,
			input logic has_err, input int pos);
		entries[i].name = name;
		entries[i].slot = slot_t'(i % 16);
		entries[i].data = data;
		entries[i].mask = has_err ? codeword_t'(1) << pos : '0;
		entries[i].exp = '{data: data, err_found: has_err, err_pos: 4'(pos)};
	endtask

	task automatic build_table();
		add_entry(0, "clean_a5", 11'h5A5, 1'b0, 0);
		add_entry(1, "clean_2c3", 11'h2C3, 1'b0, 0);
		// One entry per bit position including the parity bits
		for (int p = 0; p < bch_n; p++) begin
			add_entry(2 + p, $sformatf("flip_bit_%0d", p), bch_data_t'($urandom), 1'b1, p);
		end
		for (int i = 2 + bch_n; i < num_entries; i++) begin
			add_entry(i, $sformatf("random_%0d", i), bch_data_t'($urandom), 1'b1,
				int'($urandom % 15));
		end
	endtask

	// ##################################################
	// Scenarios

	task automatic reject_bad_accesses();
		apb_data_t rdata;
		logic err;
		apb_write(8'h18, 32'h1234_5678, err);
		check_slverr("unmapped_write", 1'b1, err);
		apb_read(8'h1C, rdata, err);
		check_slverr("unmapped_read", 1'b1, err);
		encode_entry(11);
		apb_write(reg_enc_cmd, {5'b0, ~entries[11].data, 12'b0, entries[11].slot ^ 4'd1}, err);
		check_slverr("encode_while_busy", 1'b1, err);
		wait_status_clear(0, "encoder");
		inject_entry(11);
		wait_status_clear(2, "error injection");
		decode_entry(11);
		apb_write(reg_dec_cmd, {28'b0, entries[12].slot}, err);
		check_slverr("decode_while_busy", 1'b1, err);
		wait_status_clear(1, "decoder");
		verify_entry(11);
	endtask

	task automatic decode_out_of_order();
		for (int i = 0; i < 8; i++) begin
			encode_entry(i);
			wait_status_clear(0, "encoder");
			inject_entry(i);
			wait_status_clear(2, "error injection");
		end
		for (int i = 7; i >= 0; i--) begin
			decode_entry(i);
			wait_status_clear(1, "decoder");
			verify_entry(i);
		end
	endtask

	// Injection and encode hit the store while the decoder is still busy
	task automatic decode_under_contention();
		run_entry(8);
		encode_entry(9);
		wait_status_clear(0, "encoder");
		decode_entry(8);
		inject_entry(9);
		encode_entry(10);
		wait_status_clear(1, "decoder");
		verify_entry(8);
		wait_status_clear(0, "encoder");
		wait_status_clear(2, "error injection");
		inject_entry(10);
		wait_status_clear(2, "error injection");
		decode_entry(9);
		wait_status_clear(1, "decoder");
		verify_entry(9);
		decode_entry(10);
		wait_status_clear(1, "decoder");
		verify_entry(10);
	endtask

	initial begin
		int unsigned seed_init;
		seed_init = $urandom(82);
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		reject_bad_accesses();
		for (int i = 0; i < num_entries; i++) begin
			run_entry(i);
		end
		decode_out_of_order();
		decode_under_contention();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
common/bch_pkg.sv
common/codec_regs_pkg.sv
logic/apb_regs.sv
encoder/bch_encoder.sv
decoder/bch_decoder.sv
logic/codeword_store.sv
logic/bch_codec_top.sv
dv/bch_codec_asserts.sv
dv/bch_codec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the BCH codec testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
	--top-module bch_codec_tb -f project.f \
	-Mdir obj_dir -o bch_codec_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/bch_codec_sim; then
	echo "Simulation failed"
	exit 1
fi

exit 0
